// ==== usb_pkg.sv ====
package usb_pkg;

   // bus geometry
   localparam int ADDR_W   = 4;
   localparam int DATA_W   = 32;
   localparam int BE_W     = 4;   // one enable per byte lane
   localparam int SAMPLE_W = 16;  // audio sample, signed pcm
   localparam int BYTE_W   = 8;   // cdc byte

   // register byte offsets
   localparam logic [ADDR_W-1:0] REG_CCR = 4'd0;   // class control
   localparam logic [ADDR_W-1:0] REG_RDR = 4'd4;   // receive data, hw write only
   localparam logic [ADDR_W-1:0] REG_TDR = 4'd8;   // transmit data
   localparam logic [ADDR_W-1:0] REG_STA = 4'd12;  // status

   // class codes, 2..4 were camera/disk/keyboard and now select nothing
   localparam int CLASS_W = 3;
   localparam logic [CLASS_W-1:0] CLASS_NONE   = 3'd0;
   localparam logic [CLASS_W-1:0] CLASS_AUDIO  = 3'd1;
   localparam logic [CLASS_W-1:0] CLASS_SERIAL = 3'd5;  // and anything above

   // status bits
   localparam int STA_W       = 3;
   localparam int STA_RX_FULL = 0;  // new receive data in rdr
   localparam int STA_TX_PEND = 1;  // processor asked for a send
   localparam int STA_OVERRUN = 2;  // rdr written while rx_full still set

   // serial send buffer depth in the cdc core
   localparam int CREDIT_MAX = 4;
   localparam int CREDIT_W   = 3;

   typedef struct packed {
      logic              wr;     // 1 = write, 0 = read
      logic [BE_W-1:0]   be;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] left;
      logic [SAMPLE_W-1:0] right;
   } audio_pair_t;

   typedef struct packed {
      logic [DATA_W-BYTE_W-1:0] pad;   // always zero
      logic [BYTE_W-1:0]        data;
   } ser_word_t;

   // rdr holds either a stereo pair or a zero-extended byte
   typedef union packed {
      audio_pair_t audio;
      ser_word_t   serial;
   } rdr_word_u;

   typedef struct packed {
      logic             rdr_we;
      rdr_word_u        rdr;
      logic [STA_W-1:0] sta_set;
      logic [STA_W-1:0] sta_clr;   // wins over sta_set
   } reg_update_t;

   typedef struct packed {
      logic [DATA_W-1:0] tdr;
      logic [STA_W-1:0]  sta;
      logic [DATA_W-1:0] ccr;
   } reg_view_t;

endpackage

// ==== usb_regs.sv ====
`timescale 1ns/10ps

module usb_regs (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  usb_pkg::bus_req_t           bus_i,
   output logic [usb_pkg::DATA_W-1:0]  rdata_o,
   input  usb_pkg::reg_update_t        upd_i,
   output usb_pkg::reg_view_t          view_o
);

   logic [usb_pkg::DATA_W-1:0] ccr_q;
   logic [usb_pkg::DATA_W-1:0] rdr_q;
   logic [usb_pkg::DATA_W-1:0] tdr_q;
   logic [usb_pkg::STA_W-1:0]  sta_q;
   logic [usb_pkg::STA_W-1:0]  sta_nxt;
   logic [usb_pkg::DATA_W-1:0] rdata_q;
   logic [usb_pkg::DATA_W-1:0] rd_mux;
   logic                       wr_ccr;
   logic                       wr_tdr;
   logic                       wr_sta;

   // merge the enabled byte lanes of a write into the old word
   function automatic logic [usb_pkg::DATA_W-1:0] be_merge(
      input logic [usb_pkg::DATA_W-1:0] old_w,
      input logic [usb_pkg::DATA_W-1:0] new_w,
      input logic [usb_pkg::BE_W-1:0]   be
   );
      logic [usb_pkg::DATA_W-1:0] res;
      res = old_w;
      for (int i = 0; i < usb_pkg::BE_W; i++) begin
         if (be[i])
            res[usb_pkg::BYTE_W*i +: usb_pkg::BYTE_W] = new_w[usb_pkg::BYTE_W*i +: usb_pkg::BYTE_W];
      end
      return res;
   endfunction

   // write decode, rdr has no bus write
   assign wr_ccr = bus_i.wr && (bus_i.addr == usb_pkg::REG_CCR);
   assign wr_tdr = bus_i.wr && (bus_i.addr == usb_pkg::REG_TDR);
   assign wr_sta = bus_i.wr && (bus_i.addr == usb_pkg::REG_STA);

   always_comb begin
      sta_nxt = sta_q;
      if (wr_sta && bus_i.be[0])   // status lives in lane 0
         sta_nxt = bus_i.wdata[usb_pkg::STA_W-1:0];
      sta_nxt = (sta_nxt | upd_i.sta_set) & ~upd_i.sta_clr;  // bus, then set, then clear
   end

   // read mux sees the value before this edge's writes
   always_comb begin
      case (bus_i.addr)
         usb_pkg::REG_CCR: rd_mux = ccr_q;
         usb_pkg::REG_RDR: rd_mux = rdr_q;
         usb_pkg::REG_TDR: rd_mux = tdr_q;
         usb_pkg::REG_STA: rd_mux = {{(usb_pkg::DATA_W-usb_pkg::STA_W){1'b0}}, sta_q};
         default:          rd_mux = '0;   // unaligned offsets
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ccr_q   <= '0;
         rdr_q   <= '0;
         tdr_q   <= '0;
         sta_q   <= '0;
         rdata_q <= '0;
      end else begin
         if (wr_ccr)
            ccr_q <= be_merge(ccr_q, bus_i.wdata, bus_i.be);
         if (wr_tdr)
            tdr_q <= be_merge(tdr_q, bus_i.wdata, bus_i.be);
         if (upd_i.rdr_we)
            rdr_q <= upd_i.rdr;           // hardware only
         sta_q   <= sta_nxt;
         rdata_q <= rd_mux;               // one cycle read latency
      end
   end

   assign rdata_o = rdata_q;
   assign view_o  = '{tdr: tdr_q, sta: sta_q, ccr: ccr_q};

endmodule

// ==== usb_audio_bridge.sv ====
`timescale 1ns/10ps

module usb_audio_bridge (
   input  logic                  clk_i,
   input  logic                  rst_i,       // high while audio is not selected
   input  usb_pkg::reg_view_t    view_i,
   input  logic                  audio_en_i,  // sample strobe from the audio core
   input  usb_pkg::audio_pair_t  audio_rx_i,
   output usb_pkg::audio_pair_t  audio_tx_o,
   output usb_pkg::reg_update_t  upd_o
);

   logic held_q;   // strobe seen across reset release, wait for it to drop
   logic take;

   always_ff @(posedge clk_i) begin
      if (rst_i)
         held_q <= 1'b1;
      else if (!audio_en_i)
         held_q <= 1'b0;
   end

   assign take = audio_en_i && !held_q;

   always_comb begin
      upd_o           = '0;
      upd_o.rdr_we    = take;
      upd_o.rdr.audio = audio_rx_i;   // left in the upper half
      upd_o.sta_set[usb_pkg::STA_RX_FULL] = take;
      // previous pair not yet taken by the processor
      upd_o.sta_set[usb_pkg::STA_OVERRUN] = take && view_i.sta[usb_pkg::STA_RX_FULL];
   end

   // outgoing samples come straight from tdr, the core samples on its own strobe
   assign audio_tx_o = usb_pkg::audio_pair_t'(view_i.tdr);

endmodule

// ==== usb_serial_bridge.sv ====
`timescale 1ns/10ps

module usb_serial_bridge (
   input  logic                         clk_i,
   input  logic                         rst_i,       // high while serial is not selected
   input  usb_pkg::reg_view_t           view_i,
   input  logic                         rx_valid_i,  // byte strobe from the cdc core
   input  logic [usb_pkg::BYTE_W-1:0]   rx_byte_i,
   input  logic                         credit_i,    // one send slot freed
   output logic                         tx_valid_o,
   output logic [usb_pkg::BYTE_W-1:0]   tx_byte_o,
   output usb_pkg::reg_update_t         upd_o
);

   logic [usb_pkg::CREDIT_W-1:0] credit_q;
   logic                         send;

   // one pulse per request while the core has room, never while held in reset
   assign send = view_i.sta[usb_pkg::STA_TX_PEND] && (credit_q != '0) && !rst_i;

   // credit counter, full buffer available on (re)selection
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         credit_q <= usb_pkg::CREDIT_W'(usb_pkg::CREDIT_MAX);
      end else begin
         case ({send, credit_i})
            2'b10: credit_q <= credit_q - 1'b1;
            2'b01: begin
               if (credit_q < usb_pkg::CREDIT_W'(usb_pkg::CREDIT_MAX))
                  credit_q <= credit_q + 1'b1;   // clamp at buffer depth
            end
            default: credit_q <= credit_q;       // none, or spend and return together
         endcase
      end
   end

   assign tx_valid_o = send;
   assign tx_byte_o  = view_i.tdr[usb_pkg::BYTE_W-1:0];   // low byte of tdr

   // rx and tx masks are merged so both can land in one cycle
   always_comb begin
      upd_o                 = '0;
      upd_o.rdr_we          = rx_valid_i;
      upd_o.rdr.serial.pad  = '0;
      upd_o.rdr.serial.data = rx_byte_i;
      upd_o.sta_set[usb_pkg::STA_RX_FULL] = rx_valid_i;
      upd_o.sta_set[usb_pkg::STA_OVERRUN] = rx_valid_i && view_i.sta[usb_pkg::STA_RX_FULL];
      upd_o.sta_clr[usb_pkg::STA_TX_PEND] = send;   // request consumed at this edge
   end

endmodule

// ==== usb_func_select.sv ====
`timescale 1ns/10ps

module usb_func_select (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  usb_pkg::reg_view_t    view_i,
   input  usb_pkg::reg_update_t  audio_upd_i,
   input  usb_pkg::reg_update_t  serial_upd_i,
   output usb_pkg::reg_update_t  upd_o,
   output logic                  audio_rst_o,
   output logic                  serial_rst_o
);

   logic [usb_pkg::CLASS_W-1:0] class_d;
   logic [usb_pkg::CLASS_W-1:0] class_q;   // live function

   // whole ccr word compared, so large values still mean serial
   always_comb begin
      if (view_i.ccr >= usb_pkg::DATA_W'(usb_pkg::CLASS_SERIAL))
         class_d = usb_pkg::CLASS_SERIAL;
      else if (view_i.ccr == usb_pkg::DATA_W'(usb_pkg::CLASS_AUDIO))
         class_d = usb_pkg::CLASS_AUDIO;
      else
         class_d = usb_pkg::CLASS_NONE;   // 0 and the retired codes 2..4
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         class_q <= usb_pkg::CLASS_NONE;
      else
         class_q <= class_d;   // one edge after the ccr write
   end

   // unselected function is held in reset
   assign audio_rst_o  = rst_i || (class_q != usb_pkg::CLASS_AUDIO);
   assign serial_rst_o = rst_i || (class_q != usb_pkg::CLASS_SERIAL);

   always_comb begin
      case (class_q)
         usb_pkg::CLASS_AUDIO:  upd_o = audio_upd_i;
         usb_pkg::CLASS_SERIAL: upd_o = serial_upd_i;
         default:               upd_o = '0;   // idle, nothing reaches the bank
      endcase
   end

endmodule

// ==== usb_top.sv ====
`timescale 1ns/10ps

module usb_top (
   input  logic                        clk_i,
   input  logic                        rst_i,
   // processor bus
   input  usb_pkg::bus_req_t           bus_i,
   output logic [usb_pkg::DATA_W-1:0]  rdata_o,
   // audio core
   input  logic                        audio_en_i,
   input  usb_pkg::audio_pair_t        audio_rx_i,
   output usb_pkg::audio_pair_t        audio_tx_o,
   // cdc core
   input  logic                        ser_rx_valid_i,
   input  logic [usb_pkg::BYTE_W-1:0]  ser_rx_byte_i,
   input  logic                        ser_credit_i,
   output logic                        ser_tx_valid_o,
   output logic [usb_pkg::BYTE_W-1:0]  ser_tx_byte_o,
   // per-class core resets
   output logic                        audio_rst_o,
   output logic                        serial_rst_o
);

   usb_pkg::reg_view_t   view;
   usb_pkg::reg_update_t audio_upd;
   usb_pkg::reg_update_t serial_upd;
   usb_pkg::reg_update_t upd;   // selected bridge's update

   usb_regs u_regs (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .bus_i   (bus_i),
      .rdata_o (rdata_o),
      .upd_i   (upd),
      .view_o  (view)
   );

   usb_audio_bridge u_audio (
      .clk_i      (clk_i),
      .rst_i      (audio_rst_o),   // bridge shares the core's class reset
      .view_i     (view),
      .audio_en_i (audio_en_i),
      .audio_rx_i (audio_rx_i),
      .audio_tx_o (audio_tx_o),
      .upd_o      (audio_upd)
   );

   usb_serial_bridge u_serial (
      .clk_i      (clk_i),
      .rst_i      (serial_rst_o),
      .view_i     (view),
      .rx_valid_i (ser_rx_valid_i),
      .rx_byte_i  (ser_rx_byte_i),
      .credit_i   (ser_credit_i),
      .tx_valid_o (ser_tx_valid_o),
      .tx_byte_o  (ser_tx_byte_o),
      .upd_o      (serial_upd)
   );

   usb_func_select u_select (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .view_i       (view),
      .audio_upd_i  (audio_upd),
      .serial_upd_i (serial_upd),
      .upd_o        (upd),
      .audio_rst_o  (audio_rst_o),
      .serial_rst_o (serial_rst_o)
   );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  usb_pkg::bus_req_t           bus_i,
   input  logic [usb_pkg::DATA_W-1:0]  rdata_i,
   input  logic                        audio_en_i,
   input  usb_pkg::audio_pair_t        audio_rx_i,
   input  usb_pkg::audio_pair_t        audio_tx_i,
   input  logic                        rx_valid_i,
   input  logic [usb_pkg::BYTE_W-1:0]  rx_byte_i,
   input  logic                        credit_i,
   input  logic                        tx_valid_i,
   input  logic [usb_pkg::BYTE_W-1:0]  tx_byte_i,
   input  logic                        audio_rst_i,
   input  logic                        serial_rst_i,
   output int                          err_cnt_o,
   output int                          chk_cnt_o
);

   logic [31:0] ccr;
   logic [31:0] rdr;
   logic [31:0] tdr;
   logic [31:0] rd_exp;      // what rdata must show after this edge
   logic [2:0]  sta;
   logic [2:0]  cls;         // class live in the dut
   logic        held;        // audio strobe still high from before selection
   int          credit;
   int          in_flight;   // slots the core holds for us

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
      chk_cnt_o++;
      if (got !== want) begin
         err_cnt_o++;
         $display("Fail %s got 0x%h expected 0x%h at %0t ns", name, got, want, $time);
      end
   endtask

   function automatic logic [31:0] lane_write(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  be);
      logic [31:0] keep;
      keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      return (new_w & keep) | (old_w & ~keep);
   endfunction

   // 1 is audio, 5 and any larger word is serial, everything else selects nothing
   function automatic logic [2:0] decode_class(input logic [31:0] word);
      if (word >= 32'd5)
         return usb_pkg::CLASS_SERIAL;
      if (word == 32'd1)
         return usb_pkg::CLASS_AUDIO;
      return usb_pkg::CLASS_NONE;
   endfunction

   always @(posedge clk_i) begin : model
      logic               take;
      logic               rx;
      logic               send;
      logic [2:0]         set_m;
      logic [2:0]         clr_m;
      usb_pkg::rdr_word_u word;
      if (rst_i) begin
         compare("audio_rst_o", 32'(audio_rst_i), 32'd1);
         compare("serial_rst_o", 32'(serial_rst_i), 32'd1);
         compare("ser_tx_valid_o", 32'(tx_valid_i), 32'd0);
         ccr       = '0;
         rdr       = '0;
         tdr       = '0;
         sta       = '0;
         rd_exp    = '0;
         cls       = usb_pkg::CLASS_NONE;
         held      = 1'b1;
         credit    = usb_pkg::CREDIT_MAX;
         in_flight = 0;
      end else begin
         take = (cls == usb_pkg::CLASS_AUDIO) && audio_en_i && !held;
         rx   = (cls == usb_pkg::CLASS_SERIAL) && rx_valid_i;
         send = (cls == usb_pkg::CLASS_SERIAL) && sta[usb_pkg::STA_TX_PEND] && (credit > 0);
         compare("rdata_o", rdata_i, rd_exp);
         compare("audio_tx_o", audio_tx_i, tdr);
         compare("ser_tx_valid_o", 32'(tx_valid_i), 32'(send));
         compare("ser_tx_byte_o", 32'(tx_byte_i), 32'(tdr[7:0]));
         compare("audio_rst_o", 32'(audio_rst_i), 32'(cls != usb_pkg::CLASS_AUDIO));
         compare("serial_rst_o", 32'(serial_rst_i), 32'(cls != usb_pkg::CLASS_SERIAL));
         if (tx_valid_i && in_flight >= usb_pkg::CREDIT_MAX) begin
            err_cnt_o++;
            $display("send issued while every core buffer slot was in use at %0t ns", $time);
         end
         case (bus_i.addr)   // read returns the value before this edge
            usb_pkg::REG_CCR: rd_exp = ccr;
            usb_pkg::REG_RDR: rd_exp = rdr;
            usb_pkg::REG_TDR: rd_exp = tdr;
            usb_pkg::REG_STA: rd_exp = {29'd0, sta};
            default:          rd_exp = '0;
         endcase
         if (cls != usb_pkg::CLASS_SERIAL) begin
            credit    = usb_pkg::CREDIT_MAX;   // full buffer again on selection
            in_flight = 0;
         end else begin
            if (send && !credit_i)
               credit--;
            else if (!send && credit_i && credit < usb_pkg::CREDIT_MAX)
               credit++;
            in_flight = in_flight + int'(send) - int'(credit_i);
         end
         if (cls != usb_pkg::CLASS_AUDIO)
            held = 1'b1;
         else if (!audio_en_i)
            held = 1'b0;
         cls = decode_class(ccr);   // selection follows ccr one edge late
         if (bus_i.wr && bus_i.addr == usb_pkg::REG_CCR)
            ccr = lane_write(ccr, bus_i.wdata, bus_i.be);
         if (bus_i.wr && bus_i.addr == usb_pkg::REG_TDR)
            tdr = lane_write(tdr, bus_i.wdata, bus_i.be);
         set_m = '0;
         clr_m = '0;
         if (take) begin
            word.audio = audio_rx_i;
            rdr        = word;
         end
         if (rx) begin
            word             = '0;
            word.serial.data = rx_byte_i;   // zero-extended byte
            rdr              = word;
         end
         set_m[usb_pkg::STA_RX_FULL] = take || rx;
         set_m[usb_pkg::STA_OVERRUN] = (take || rx) && sta[usb_pkg::STA_RX_FULL];
         clr_m[usb_pkg::STA_TX_PEND] = send;
         if (bus_i.wr && bus_i.addr == usb_pkg::REG_STA && bus_i.be[0])
            sta = bus_i.wdata[2:0];
         sta = (sta | set_m) & ~clr_m;   // bus first, then set, then clear
      end
   end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

   localparam int CLK_PERIOD  = 8;
   localparam int RST_CYCLES  = 5;
   localparam int NUM_CYCLES  = 5000;   // random cycles after the reset reads
   localparam int WATCHDOG_NS = (RST_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

   // named after the dut ports so the instance connects by name
   logic                        clk_i;
   logic                        rst_i;
   usb_pkg::bus_req_t           bus_i;
   logic [usb_pkg::DATA_W-1:0]  rdata_o;
   logic                        audio_en_i;
   usb_pkg::audio_pair_t        audio_rx_i;
   usb_pkg::audio_pair_t        audio_tx_o;
   logic                        ser_rx_valid_i;
   logic [usb_pkg::BYTE_W-1:0]  ser_rx_byte_i;
   logic                        ser_credit_i;
   logic                        ser_tx_valid_o;
   logic [usb_pkg::BYTE_W-1:0]  ser_tx_byte_o;
   logic                        audio_rst_o;
   logic                        serial_rst_o;
   logic                        sent_q;     // a send left the dut at the last edge
   integer                      seed;
   int                          cycle;
   int                          due_q[$];   // cycle at which each spent slot comes back
   int                          err_cnt;
   int                          chk_cnt;

   usb_top u_dut (.*);

   tb_checker u_chk (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .bus_i        (bus_i),
      .rdata_i      (rdata_o),
      .audio_en_i   (audio_en_i),
      .audio_rx_i   (audio_rx_i),
      .audio_tx_i   (audio_tx_o),
      .rx_valid_i   (ser_rx_valid_i),
      .rx_byte_i    (ser_rx_byte_i),
      .credit_i     (ser_credit_i),
      .tx_valid_i   (ser_tx_valid_o),
      .tx_byte_i    (ser_tx_byte_o),
      .audio_rst_i  (audio_rst_o),
      .serial_rst_i (serial_rst_o),
      .err_cnt_o    (err_cnt),
      .chk_cnt_o    (chk_cnt)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   always @(posedge clk_i)
      sent_q <= ser_tx_valid_o;

   // one random cycle of bus traffic, core strobes and returned credits
   task automatic drive_random();
      logic [31:0] r0;
      logic [31:0] r1;
      r0 = $random(seed);
      r1 = $random(seed);
      bus_i.wr    = r0[0];
      bus_i.be    = r0[5:2];
      bus_i.addr  = {r0[7:6], 2'b00};     // the four register offsets
      bus_i.wdata = $random(seed);
      if (bus_i.addr == usb_pkg::REG_CCR) begin
         bus_i.wr = bus_i.wr && (r0[9:8] == 2'b00);   // class changes stay rare
         if (r0[31:29] != 3'd0)
            bus_i.wdata = {29'd0, r0[13:11]};          // mostly small class codes
      end
      audio_en_i     = (r0[15:14] == 2'b00);
      audio_rx_i     = r1;
      ser_rx_valid_i = (r0[18:16] == 3'd0);
      ser_rx_byte_i  = r0[26:19];
      ser_credit_i   = 1'b0;
      if (serial_rst_o) begin
         due_q.delete();                   // core buffer flushed in reset
      end else begin
         if (sent_q)
            due_q.push_back(cycle + 30 + int'(r1[5:0]));
         if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            ser_credit_i = 1'b1;           // never more than were spent
         end
      end
   endtask

   initial begin
      seed           = 94;
      cycle          = 0;
      rst_i          = 1'b1;
      bus_i          = '0;
      audio_en_i     = 1'b0;
      audio_rx_i     = '0;
      ser_rx_valid_i = 1'b0;
      ser_rx_byte_i  = '0;
      ser_credit_i   = 1'b0;
      repeat (RST_CYCLES) @(negedge clk_i);
      rst_i = 1'b0;
      for (int i = 0; i < 4; i++) begin   // read every register straight after reset
         bus_i.addr = usb_pkg::ADDR_W'(i * 4);
         @(negedge clk_i);
      end
      repeat (NUM_CYCLES) begin
         cycle++;
         drive_random();
         @(negedge clk_i);
      end
      bus_i          = '0;
      audio_en_i     = 1'b0;
      ser_rx_valid_i = 1'b0;
      ser_credit_i   = 1'b0;
      repeat (2) @(negedge clk_i);        // let the last read come back
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== tb.f ====
usb_pkg.sv
usb_regs.sv
usb_audio_bridge.sv
usb_serial_bridge.sv
usb_func_select.sv
usb_top.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the usb glue testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
exit 0
